// File: hw/cpu_ctrl_if.sv
`timescale 1ns/10ps

interface cpu_ctrl_if import cpu_pkg::*; ();

    reg_sel_e reg_sel;
    wb_src_e  wb_src;
    logic     reg_wr_en;

    // operand registers and ALU input muxes
    logic     load_a;
    logic     load_b;
    logic     zero_a;
    logic     use_imm5;

    logic     load_c;
    logic     load_status;

    modport ctrl (
        output reg_sel, wb_src, reg_wr_en,
        output load_a, load_b, zero_a, use_imm5,
        output load_c, load_status
    );

    modport dp (
        input reg_sel, wb_src, reg_wr_en,
        input load_a, load_b, zero_a, use_imm5,
        input load_c, load_status
    );

endinterface : cpu_ctrl_if

// File: hw/cpu_pkg.sv
package cpu_pkg;

    // major opcode in instruction bits 15:13
    typedef enum logic [2:0] {
        op_ldr  = 3'b011,
        op_str  = 3'b100,
        op_alu  = 3'b101,
        op_mov  = 3'b110,
        op_halt = 3'b111
    } opcode_e;

    // operation field in bits 12:11
    // op_mov uses alu_and for the immediate form and alu_add for the register form
    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_cmp = 2'b01,
        alu_and = 2'b10,
        alu_mvn = 2'b11
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_result = 2'b00,
        wb_imm8   = 2'b10,
        wb_mem    = 2'b11
    } wb_src_e;

    typedef enum logic [1:0] {
        sel_rm = 2'b00,
        sel_rd = 2'b01,
        sel_rn = 2'b10
    } reg_sel_e;

    typedef enum logic [3:0] {
        st_reset,
        st_pc_load,
        st_read_wait,
        st_ir_load,
        st_decode,
        st_read_a,
        st_read_b,
        st_exec,
        st_exec_store,
        st_addr_load,
        st_mem_read,
        st_write_back,
        st_mem_write,
        st_halt
    } seq_state_e;

endpackage : cpu_pkg

// File: hw/cpu_top.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_ADDR_W-1:0] start_pc,
    input  logic [`CPU_WORD_W-1:0] mem_rdata,
    output logic [`CPU_ADDR_W-1:0] mem_addr,
    output logic                   mem_wr_en,
    output logic [`CPU_WORD_W-1:0] mem_wdata,
    output logic [`CPU_WORD_W-1:0] result,
    output logic                   flag_z,
    output logic                   flag_n,
    output logic                   flag_v,
    output logic                   halted
);

    logic [`CPU_ADDR_W-1:0]    pc;
    logic [`CPU_WORD_W-1:0]    ir;
    logic [`CPU_ADDR_W-1:0]    data_addr;
    opcode_e                   opcode;
    alu_op_e                   alu_op;
    logic [`CPU_REG_IDX_W-1:0] reg_idx;
    logic [`CPU_WORD_W-1:0]    imm8_sx;
    logic [`CPU_WORD_W-1:0]    imm5_sx;
    logic                      load_ir;
    logic                      load_pc;
    logic                      restart_pc;
    logic                      load_addr;
    logic                      use_pc_addr;

    cpu_ctrl_if ctrl_bus ();

    // pc follows start_pc during reset so the first fetch sees it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= start_pc;
        end else if (load_pc) begin
            pc <= restart_pc ? start_pc : pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_ir) begin
            ir <= mem_rdata;
        end
        if (load_addr) begin
            data_addr <= result[`CPU_ADDR_W-1:0];
        end
    end

    assign mem_addr  = use_pc_addr ? pc : data_addr;
    assign mem_wdata = result;

    instr_decoder i_decoder (
        .ir      (ir),
        .ctrl    (ctrl_bus.dp),
        .opcode  (opcode),
        .alu_op  (alu_op),
        .reg_idx (reg_idx),
        .imm8_sx (imm8_sx),
        .imm5_sx (imm5_sx)
    );

    sequencer i_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .opcode      (opcode),
        .alu_op      (alu_op),
        .ctrl        (ctrl_bus.ctrl),
        .load_ir     (load_ir),
        .load_pc     (load_pc),
        .restart_pc  (restart_pc),
        .load_addr   (load_addr),
        .use_pc_addr (use_pc_addr),
        .mem_wr_en   (mem_wr_en),
        .halted      (halted)
    );

    datapath i_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl_bus.dp),
        .alu_op    (alu_op),
        .reg_idx   (reg_idx),
        .imm8_sx   (imm8_sx),
        .imm5_sx   (imm5_sx),
        .mem_rdata (mem_rdata),
        .result    (result),
        .flag_z    (flag_z),
        .flag_n    (flag_n),
        .flag_v    (flag_v)
    );

endmodule : cpu_top

// File: hw/datapath.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module datapath import cpu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    cpu_ctrl_if.dp                    ctrl,
    input  alu_op_e                   alu_op,
    input  logic [`CPU_REG_IDX_W-1:0] reg_idx,
    input  logic [`CPU_WORD_W-1:0]    imm8_sx,
    input  logic [`CPU_WORD_W-1:0]    imm5_sx,
    input  logic [`CPU_WORD_W-1:0]    mem_rdata,
    output logic [`CPU_WORD_W-1:0]    result,
    output logic                      flag_z,
    output logic                      flag_n,
    output logic                      flag_v
);

    logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];
    logic [`CPU_WORD_W-1:0] rd_data;
    logic [`CPU_WORD_W-1:0] wr_data;
    logic [`CPU_WORD_W-1:0] reg_a;
    logic [`CPU_WORD_W-1:0] reg_b;
    logic [`CPU_WORD_W-1:0] alu_a;
    logic [`CPU_WORD_W-1:0] alu_b;
    logic [`CPU_WORD_W-1:0] alu_out;
    logic [`CPU_WORD_W-1:0] diff;
    logic                   cmp_z;
    logic                   cmp_v;
    logic                   cmp_n;

    // the read port and the write port share reg_idx
    assign rd_data = regs[reg_idx];

    always_comb begin
        case (ctrl.wb_src)
            wb_imm8: wr_data = imm8_sx;
            wb_mem:  wr_data = mem_rdata;
            default: wr_data = result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.reg_wr_en) begin
            regs[reg_idx] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_a) begin
            reg_a <= rd_data;
        end
        if (ctrl.load_b) begin
            reg_b <= rd_data;
        end
    end

    assign alu_a = ctrl.zero_a ? '0 : reg_a;
    assign alu_b = ctrl.use_imm5 ? imm5_sx : reg_b;
    assign diff  = alu_a - alu_b;

    always_comb begin
        case (alu_op)
            alu_add: alu_out = alu_a + alu_b;
            alu_cmp: alu_out = diff;
            alu_and: alu_out = alu_a & alu_b;
            default: alu_out = ~alu_b;
        endcase
    end

    // Z has priority over V and V over N
    assign cmp_z = (diff == '0);
    assign cmp_v = !cmp_z && (alu_a[`CPU_WORD_W-1] != alu_b[`CPU_WORD_W-1])
                   && (diff[`CPU_WORD_W-1] != alu_a[`CPU_WORD_W-1]);
    assign cmp_n = !cmp_z && !cmp_v && diff[`CPU_WORD_W-1];

    always_ff @(posedge clk) begin
        if (ctrl.load_c) begin
            result <= alu_out;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag_z <= 1'b0;
            flag_n <= 1'b0;
            flag_v <= 1'b0;
        end else if (ctrl.load_status) begin
            flag_z <= cmp_z;
            flag_n <= cmp_n;
            flag_v <= cmp_v;
        end
    end

endmodule : datapath

// File: hw/instr_decoder.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module instr_decoder import cpu_pkg::*; (
    input  logic [`CPU_WORD_W-1:0]    ir,
    cpu_ctrl_if.dp                    ctrl,
    output opcode_e                   opcode,
    output alu_op_e                   alu_op,
    output logic [`CPU_REG_IDX_W-1:0] reg_idx,
    output logic [`CPU_WORD_W-1:0]    imm8_sx,
    output logic [`CPU_WORD_W-1:0]    imm5_sx
);

    assign opcode = opcode_e'(ir[15:13]);
    assign alu_op = alu_op_e'(ir[12:11]);

    assign imm8_sx = {{(`CPU_WORD_W - 8){ir[7]}}, ir[7:0]};
    assign imm5_sx = {{(`CPU_WORD_W - 5){ir[4]}}, ir[4:0]};

    // the shift field in bits 4:3 is ignored
    always_comb begin
        case (ctrl.reg_sel)
            sel_rm:  reg_idx = ir[2:0];
            sel_rd:  reg_idx = ir[7:5];
            sel_rn:  reg_idx = ir[10:8];
            default: reg_idx = '0;
        endcase
    end

endmodule : instr_decoder

// File: hw/sequencer.sv
`timescale 1ns/10ps

module sequencer import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  opcode_e opcode,
    input  alu_op_e alu_op,
    cpu_ctrl_if.ctrl ctrl,
    output logic    load_ir,
    output logic    load_pc,
    output logic    restart_pc,
    output logic    load_addr,
    output logic    use_pc_addr,
    output logic    mem_wr_en,
    output logic    halted
);

    seq_state_e state;
    seq_state_e state_next;
    logic       is_mem_op;
    logic       is_cmp;

    assign is_mem_op = (opcode == op_ldr) || (opcode == op_str);
    assign is_cmp    = (opcode == op_alu) && (alu_op == alu_cmp);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_reset;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            // the reset state doubles as the first pc load
            st_reset:     state_next = st_read_wait;
            st_pc_load:   state_next = st_read_wait;
            st_read_wait: state_next = st_ir_load;
            st_ir_load:   state_next = st_decode;
            st_decode: begin
                case (opcode)
                    op_mov: begin
                        if (alu_op == alu_and) begin
                            state_next = st_write_back;
                        end else if (alu_op == alu_add) begin
                            state_next = st_read_b;
                        end else begin
                            state_next = st_halt;
                        end
                    end
                    op_alu:         state_next = (alu_op == alu_mvn) ? st_read_b : st_read_a;
                    op_ldr, op_str: state_next = st_read_a;
                    default:        state_next = st_halt;
                endcase
            end
            st_read_a:     state_next = is_mem_op ? st_exec : st_read_b;
            st_read_b:     state_next = (opcode == op_str) ? st_exec_store : st_exec;
            st_exec: begin
                if (is_mem_op) begin
                    state_next = st_addr_load;
                end else if (is_cmp) begin
                    state_next = st_pc_load;
                end else begin
                    state_next = st_write_back;
                end
            end
            // STR reads its data register only after the address is latched
            st_addr_load:  state_next = (opcode == op_ldr) ? st_mem_read : st_read_b;
            st_mem_read:   state_next = st_write_back;
            st_write_back: state_next = st_pc_load;
            st_exec_store: state_next = st_mem_write;
            st_mem_write:  state_next = st_pc_load;
            st_halt:       state_next = st_halt;
            default:       state_next = st_halt;
        endcase
    end

    always_comb begin
        ctrl.reg_sel     = sel_rm;
        ctrl.wb_src      = wb_result;
        ctrl.reg_wr_en   = 1'b0;
        ctrl.load_a      = 1'b0;
        ctrl.load_b      = 1'b0;
        ctrl.zero_a      = 1'b0;
        ctrl.use_imm5    = 1'b0;
        ctrl.load_c      = 1'b0;
        ctrl.load_status = 1'b0;
        load_ir          = 1'b0;
        load_pc          = 1'b0;
        restart_pc       = 1'b0;
        load_addr        = 1'b0;
        use_pc_addr      = 1'b1;
        mem_wr_en        = 1'b0;
        halted           = 1'b0;
        case (state)
            st_reset: begin
                load_pc    = 1'b1;
                restart_pc = 1'b1;
            end
            st_pc_load: load_pc = 1'b1;
            st_ir_load: load_ir = 1'b1;
            st_read_a: begin
                ctrl.reg_sel = sel_rn;
                ctrl.load_a  = 1'b1;
            end
            st_read_b: begin
                ctrl.reg_sel = (opcode == op_str) ? sel_rd : sel_rm;
                ctrl.load_b  = 1'b1;
            end
            st_exec: begin
                ctrl.zero_a      = (opcode == op_mov);
                ctrl.use_imm5    = is_mem_op;
                ctrl.load_c      = !is_cmp;
                // CMP only updates the flags
                ctrl.load_status = is_cmp;
            end
            st_exec_store: begin
                ctrl.zero_a = 1'b1;
                ctrl.load_c = 1'b1;
            end
            st_addr_load: load_addr = 1'b1;
            st_mem_read:  use_pc_addr = 1'b0;
            st_write_back: begin
                ctrl.reg_wr_en = 1'b1;
                if (opcode == op_mov && alu_op == alu_and) begin
                    ctrl.reg_sel = sel_rn;
                    ctrl.wb_src  = wb_imm8;
                end else if (opcode == op_ldr) begin
                    ctrl.reg_sel = sel_rd;
                    ctrl.wb_src  = wb_mem;
                end else begin
                    ctrl.reg_sel = sel_rd;
                end
            end
            st_mem_write: begin
                use_pc_addr = 1'b0;
                mem_wr_en   = 1'b1;
            end
            st_halt: halted = 1'b1;
            default: ;
        endcase
    end

endmodule : sequencer

// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// instruction and data word width
`define CPU_WORD_W 16

// memory address and pc width
`define CPU_ADDR_W 8

// general register file
`define CPU_NUM_REGS 8
`define CPU_REG_IDX_W 3

`endif

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --timescale 1ns/10ps --top-module tb_cpu \
    -f verilog.f -o tb_cpu_sim

out=$(./obj_dir/tb_cpu_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

// File: tests/tb_clock.sv
`timescale 1ns/10ps

// free-running clock
module tb_clock #(
    parameter int period_ns = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule : tb_clock

// File: tests/tb_cpu.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module tb_cpu;

    localparam int num_tests      = 11;
    localparam int timeout_cycles = num_tests * 40 * 12;

    // instruction fields as the ISA defines them
    localparam logic [2:0]  opc_ldr    = 3'b011;
    localparam logic [2:0]  opc_str    = 3'b100;
    localparam logic [2:0]  opc_alu    = 3'b101;
    localparam logic [2:0]  opc_mov    = 3'b110;
    localparam logic [1:0]  op_add     = 2'b00;
    localparam logic [1:0]  op_cmp     = 2'b01;
    localparam logic [1:0]  op_and     = 2'b10;
    localparam logic [1:0]  op_mvn     = 2'b11;
    localparam logic [15:0] halt_instr = 16'he000;

    // expected flags packed as {z, v, n}
    localparam logic [2:0] fl_none = 3'b000;
    localparam logic [2:0] fl_z    = 3'b100;
    localparam logic [2:0] fl_v    = 3'b010;
    localparam logic [2:0] fl_n    = 3'b001;

    logic                   clk;
    logic                   rst_n;
    logic [`CPU_ADDR_W-1:0] start_pc;
    logic [`CPU_WORD_W-1:0] mem_rdata = '0;
    logic [`CPU_ADDR_W-1:0] mem_addr;
    logic                   mem_wr_en;
    logic [`CPU_WORD_W-1:0] mem_wdata;
    logic [`CPU_WORD_W-1:0] result;
    logic                   flag_z;
    logic                   flag_n;
    logic                   flag_v;
    logic                   halted;

    logic [`CPU_WORD_W-1:0] mem [256];
    logic [`CPU_ADDR_W-1:0] last_st_addr;
    logic [`CPU_WORD_W-1:0] last_st_word;
    logic [`CPU_ADDR_W-1:0] prog_ptr;
    int                     store_count = 0;
    int                     cycle_count = 0;
    int                     num_checks  = 0;
    int                     num_errors  = 0;
    int                     num_added   = 0;

    string                  tst_name    [num_tests];
    logic [`CPU_ADDR_W-1:0] tst_start   [num_tests];
    logic [`CPU_WORD_W-1:0] tst_result  [num_tests];
    logic [2:0]             tst_flags   [num_tests];
    logic                   tst_stores  [num_tests];
    logic [`CPU_ADDR_W-1:0] tst_st_addr [num_tests];
    logic [`CPU_WORD_W-1:0] tst_st_word [num_tests];

    tb_clock i_clock (.clk(clk));

    cpu_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_pc  (start_pc),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wr_en (mem_wr_en),
        .mem_wdata (mem_wdata),
        .result    (result),
        .flag_z    (flag_z),
        .flag_n    (flag_n),
        .flag_v    (flag_v),
        .halted    (halted)
    );

    // word memory with one cycle of read latency
    // a read in the write cycle sees the old word
    always @(posedge clk) begin
        mem_rdata <= mem[mem_addr];
        if (mem_wr_en) begin
            mem[mem_addr] = mem_wdata;
            last_st_addr <= mem_addr;
            last_st_word <= mem_wdata;
            store_count  <= store_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: a program did not halt within %0d cycles", timeout_cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [15:0] mov_imm(input logic [2:0] rn, input logic [7:0] imm);
        return {opc_mov, 2'b10, rn, imm};
    endfunction

    function automatic logic [15:0] mov_reg(input logic [2:0] rd, input logic [2:0] rm);
        return {opc_mov, 2'b00, 3'b000, rd, 2'b00, rm};
    endfunction

    function automatic logic [15:0] alu_rr(input logic [1:0] op, input logic [2:0] rd,
                                           input logic [2:0] rn, input logic [2:0] rm);
        return {opc_alu, op, rn, rd, 2'b00, rm};
    endfunction

    function automatic logic [15:0] ldr_imm(input logic [2:0] rd, input logic [2:0] rn,
                                            input logic [4:0] imm);
        return {opc_ldr, op_add, rn, rd, imm};
    endfunction

    function automatic logic [15:0] str_imm(input logic [2:0] rd, input logic [2:0] rn,
                                            input logic [4:0] imm);
        return {opc_str, op_add, rn, rd, imm};
    endfunction

    task automatic set_origin(input logic [7:0] addr);
        prog_ptr = addr;
    endtask

    task automatic emit(input logic [15:0] word);
        mem[prog_ptr] = word;
        prog_ptr = prog_ptr + 8'd1;
    endtask

    task automatic fill_memory;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {~(8'(i)), 8'(i)};
        end
        mem[8'he0] = 16'h7ff0;
        mem[8'he1] = 16'h8000;
    endtask

    task automatic load_programs;
        set_origin(8'h00);
        emit(mov_imm(3'd1, 8'h5a));
        emit(mov_reg(3'd2, 3'd1));
        emit(halt_instr);
        set_origin(8'h08);
        emit(mov_imm(3'd3, 8'h9c));
        emit(mov_reg(3'd4, 3'd3));
        emit(halt_instr);
        // cmp first so the later alu op must keep its flag
        set_origin(8'h10);
        emit(mov_imm(3'd1, 8'h80));
        emit(mov_imm(3'd2, 8'h90));
        emit(alu_rr(op_cmp, 3'd0, 3'd1, 3'd1));
        emit(alu_rr(op_add, 3'd3, 3'd1, 3'd2));
        emit(halt_instr);
        set_origin(8'h18);
        emit(mov_imm(3'd1, 8'hc3));
        emit(mov_imm(3'd2, 8'h5e));
        emit(alu_rr(op_cmp, 3'd0, 3'd1, 3'd2));
        emit(alu_rr(op_and, 3'd3, 3'd2, 3'd1));
        emit(halt_instr);
        set_origin(8'h20);
        emit(mov_imm(3'd4, 8'h40));
        emit(mov_imm(3'd5, 8'h3c));
        emit(alu_rr(op_cmp, 3'd0, 3'd5, 3'd4));
        emit(alu_rr(op_mvn, 3'd6, 3'd0, 3'd5));
        emit(halt_instr);
        set_origin(8'h28);
        emit(mov_imm(3'd1, 8'h11));
        emit(mov_reg(3'd2, 3'd1));
        emit(alu_rr(op_cmp, 3'd0, 3'd1, 3'd2));
        emit(halt_instr);
        // large operands come from the data words at 0xe0
        set_origin(8'h30);
        emit(mov_imm(3'd0, 8'he0));
        emit(ldr_imm(3'd1, 3'd0, 5'd0));
        emit(mov_imm(3'd2, 8'h80));
        emit(mov_reg(3'd3, 3'd1));
        emit(alu_rr(op_cmp, 3'd0, 3'd1, 3'd2));
        emit(halt_instr);
        set_origin(8'h38);
        emit(mov_imm(3'd1, 8'h05));
        emit(mov_imm(3'd2, 8'h09));
        emit(mov_reg(3'd3, 3'd2));
        emit(alu_rr(op_cmp, 3'd0, 3'd1, 3'd2));
        emit(halt_instr);
        set_origin(8'h40);
        emit(mov_imm(3'd1, 8'h09));
        emit(mov_imm(3'd2, 8'h05));
        emit(alu_rr(op_cmp, 3'd0, 3'd2, 3'd1));
        emit(mov_reg(3'd3, 3'd1));
        emit(alu_rr(op_cmp, 3'd0, 3'd1, 3'd2));
        emit(halt_instr);
        // 0xfff0 plus imm5 -5 wraps to address 0xeb
        set_origin(8'h48);
        emit(mov_imm(3'd0, 8'hf0));
        emit(mov_imm(3'd4, 8'ha5));
        emit(str_imm(3'd4, 3'd0, 5'h1b));
        emit(mov_imm(3'd5, 8'h00));
        emit(ldr_imm(3'd5, 3'd0, 5'h1b));
        emit(mov_reg(3'd6, 3'd5));
        emit(halt_instr);
        set_origin(8'h50);
        emit(mov_imm(3'd0, 8'he0));
        emit(ldr_imm(3'd1, 3'd0, 5'd1));
        emit(mov_imm(3'd2, 8'h01));
        emit(mov_reg(3'd3, 3'd2));
        emit(alu_rr(op_cmp, 3'd0, 3'd1, 3'd2));
        emit(halt_instr);
    endtask

    task automatic add_test(input string name, input logic [7:0] start,
                            input logic [15:0] res, input logic [2:0] flags,
                            input logic stores, input logic [7:0] st_addr,
                            input logic [15:0] st_word);
        tst_name[num_added]    = name;
        tst_start[num_added]   = start;
        tst_result[num_added]  = res;
        tst_flags[num_added]   = flags;
        tst_stores[num_added]  = stores;
        tst_st_addr[num_added] = st_addr;
        tst_st_word[num_added] = st_word;
        num_added = num_added + 1;
    endtask

    task automatic build_tests;
        add_test("mov_imm_pos", 8'h00, 16'h005a, fl_none, 1'b0, 8'h00, 16'h0000);
        add_test("mov_imm_neg", 8'h08, 16'hff9c, fl_none, 1'b0, 8'h00, 16'h0000);
        add_test("add_wrap", 8'h10, 16'hff10, fl_z, 1'b0, 8'h00, 16'h0000);
        add_test("and_keeps_n", 8'h18, 16'h0042, fl_n, 1'b0, 8'h00, 16'h0000);
        add_test("mvn", 8'h20, 16'hffc3, fl_n, 1'b0, 8'h00, 16'h0000);
        add_test("cmp_equal", 8'h28, 16'h0011, fl_z, 1'b0, 8'h00, 16'h0000);
        add_test("cmp_overflow_pos", 8'h30, 16'h7ff0, fl_v, 1'b0, 8'h00, 16'h0000);
        add_test("cmp_negative", 8'h38, 16'h0009, fl_n, 1'b0, 8'h00, 16'h0000);
        add_test("cmp_positive", 8'h40, 16'h0009, fl_none, 1'b0, 8'h00, 16'h0000);
        add_test("str_ldr", 8'h48, 16'hffa5, fl_none, 1'b1, 8'heb, 16'hffa5);
        add_test("cmp_overflow_neg", 8'h50, 16'h0001, fl_v, 1'b0, 8'h00, 16'h0000);
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [15:0] expected, input logic [15:0] actual);
        num_checks = num_checks + 1;
        if (actual !== expected) begin
            num_errors = num_errors + 1;
            $display("mismatch %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    initial begin
        int t;
        int hold;
        int stores_before;
        rst_n    = 1'b0;
        start_pc = '0;
        fill_memory;
        load_programs;
        build_tests;
        for (t = 0; t < num_tests; t++) begin
            hold = (t == 0) ? 16 : 2;
            @(negedge clk);
            rst_n    = 1'b0;
            start_pc = tst_start[t];
            repeat (hold) @(negedge clk);
            check_value(tst_name[t], "reset halted", 16'd0, 16'(halted));
            check_value(tst_name[t], "reset mem_wr_en", 16'd0, 16'(mem_wr_en));
            check_value(tst_name[t], "reset flags", 16'd0, 16'({flag_z, flag_v, flag_n}));
            check_value(tst_name[t], "first fetch addr", 16'(tst_start[t]), 16'(mem_addr));
            stores_before = store_count;
            rst_n = 1'b1;
            @(negedge clk);
            while (halted !== 1'b1) begin
                @(negedge clk);
            end
            check_value(tst_name[t], "result", tst_result[t], result);
            check_value(tst_name[t], "flags", 16'(tst_flags[t]),
                        16'({flag_z, flag_v, flag_n}));
            check_value(tst_name[t], "stores", 16'(tst_stores[t]),
                        16'(store_count - stores_before));
            if (tst_stores[t]) begin
                check_value(tst_name[t], "store addr", 16'(tst_st_addr[t]),
                            16'(last_st_addr));
                check_value(tst_name[t], "store word", tst_st_word[t], last_st_word);
            end
            repeat (2) @(negedge clk);
            check_value(tst_name[t], "halted held", 16'd1, 16'(halted));
        end
        $display("tb_cpu: %0d checks, %0d errors", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_cpu

// File: verilog.f
+incdir+include
hw/cpu_pkg.sv
hw/cpu_ctrl_if.sv
hw/instr_decoder.sv
hw/sequencer.sv
hw/datapath.sv
hw/cpu_top.sv
tests/tb_clock.sv
tests/tb_cpu.sv
